// File: tb.f
source/board_pkg.sv
source/video_pkg.sv
source/tick_gen.sv
source/vga_timing.sv
source/tm1638_controller.sv
source/lab_top.sv
source/board_top.sv
tb/tb_checker.sv
tb/tb_top.sv

// File: Bender.yml
package:
  name: board_lab

sources:
  - source/board_pkg.sv
  - source/video_pkg.sv
  - source/tick_gen.sv
  - source/vga_timing.sv
  - source/tm1638_controller.sv
  - source/lab_top.sv
  - source/board_top.sv
  - target: test
    files:
      - tb/tb_checker.sv
      - tb/tb_top.sv

// File: tb/tb_top.sv
`timescale 1ns/1ps
`default_nettype none

module tb_top
    import video_pkg::*;
;

    localparam int tick_cycles = 40;   // Short tick for simulation
    localparam int pix_div     = 2;
    localparam int sio_div     = 2;
    localparam int h_display   = 16;   // Tiny raster
    localparam int h_front     = 2;
    localparam int h_sync      = 3;
    localparam int h_back      = 3;
    localparam int v_display   = 8;
    localparam int v_front     = 1;
    localparam int v_sync      = 2;
    localparam int v_back      = 2;
    localparam int n_frames    = 10;   // Serial frames to observe
    localparam int max_cycles  = 60000;
    localparam int seg_cycles  = 2500; // Clocks between input changes

    logic        clk;
    logic        rst;
    logic [1:0]  KEY;
    logic [2:0]  SW;
    logic [7:0]  LED;
    logic        HDMI_TX_CLK;
    logic        HDMI_TX_DE;
    logic [23:0] HDMI_TX_D;
    logic        HDMI_TX_HS;
    logic        HDMI_TX_VS;
    logic        tm_stb;
    logic        tm_clk;
    logic        tm_data;
    logic [31:0] lfsr_state;
    int          mismatches;
    int          other_errors;
    int          frames;
    int          checked_frames;

    // Fibonacci LFSR with taps 32 22 2 1
    function automatic logic [31:0] draw_bits(input int n);
        logic        fb;
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            v          = {v[30:0], fb};
        end
        return v;
    endfunction

    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;  // 8 ns period
    end

    board_top
    #(
        .clk_mhz     (50),
        .tick_cycles (tick_cycles),
        .pix_div     (pix_div),
        .sio_div     (sio_div),
        .h_display   (h_display),
        .h_front     (h_front),
        .h_sync      (h_sync),
        .h_back      (h_back),
        .v_display   (v_display),
        .v_front     (v_front),
        .v_sync      (v_sync),
        .v_back      (v_back)
    )
    i_board_top
    (
        .clk         (clk),
        .rst         (rst),
        .KEY         (KEY),
        .SW          (SW),
        .LED         (LED),
        .HDMI_TX_CLK (HDMI_TX_CLK),
        .HDMI_TX_DE  (HDMI_TX_DE),
        .HDMI_TX_D   (HDMI_TX_D),
        .HDMI_TX_HS  (HDMI_TX_HS),
        .HDMI_TX_VS  (HDMI_TX_VS),
        .tm_stb      (tm_stb),
        .tm_clk      (tm_clk),
        .tm_data     (tm_data)
    );

    tb_checker
    #(
        .tick_cycles (tick_cycles), .pix_div (pix_div), .sio_div (sio_div),
        .h_display (h_display), .h_front (h_front), .h_sync (h_sync), .h_back (h_back),
        .v_display (v_display), .v_front (v_front), .v_sync (v_sync), .v_back (v_back)
    )
    i_tb_checker
    (
        .clk (clk), .rst (rst), .KEY (KEY), .SW (SW), .LED (LED),
        .HDMI_TX_CLK (HDMI_TX_CLK), .HDMI_TX_DE (HDMI_TX_DE), .HDMI_TX_D (HDMI_TX_D),
        .HDMI_TX_HS (HDMI_TX_HS), .HDMI_TX_VS (HDMI_TX_VS),
        .tm_stb (tm_stb), .tm_clk (tm_clk), .tm_data (tm_data),
        .mismatches (mismatches), .other_errors (other_errors),
        .frames (frames), .checked_frames (checked_frames)
    );

    //--------------------------------------------------
    // Stimulus

    initial
    begin
        int          cyc;
        int          seg_idx;
        logic [31:0] r;
        logic        timed_out;
        lfsr_state = 32'h3bee;
        rst        = 1'b1;
        KEY        = 2'b11;  // No button pressed
        SW         = 3'd0;
        cyc        = 0;
        seg_idx    = 0;
        timed_out  = 1'b0;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        while (frames < n_frames && !timed_out)
        begin
            @(posedge clk);
            cyc++;
            if (cyc % seg_cycles == 0)
            begin
                r = draw_bits(4);
                SW  <= r[2:0];
                KEY <= {r[3], seg_idx[0]};  // Alternate hold and run
                seg_idx++;
            end
            if (cyc >= max_cycles)
                timed_out = 1'b1;
        end
        if (timed_out)
            $display("Timeout: only %0d serial frames seen in %0d clocks", frames, cyc);
        if (checked_frames == 0)
            $display("No serial frame had settled digits to compare");
        $display("Errors: %0d mismatches, %0d other failures, %0d frames, %0d digit checks",
                 mismatches, other_errors, frames, checked_frames);
        if (mismatches == 0 && other_errors == 0 && !timed_out && checked_frames > 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: tb/tb_checker.sv
`timescale 1ns/1ps
`default_nettype none

module tb_checker
    import board_pkg::*;
    import video_pkg::*;
#(
    parameter int tick_cycles = 40,
    parameter int pix_div     = 2,
    parameter int sio_div     = 2,
    parameter int h_display   = 16,
    parameter int h_front     = 2,
    parameter int h_sync      = 3,
    parameter int h_back      = 3,
    parameter int v_display   = 8,
    parameter int v_front     = 1,
    parameter int v_sync      = 2,
    parameter int v_back      = 2
)
(
    input  logic             clk,
    input  logic             rst,
    input  logic [w_key-1:0] KEY,
    input  logic [w_sw-1:0]  SW,
    input  logic [w_led-1:0] LED,
    input  logic             HDMI_TX_CLK,
    input  logic             HDMI_TX_DE,
    input  logic [23:0]      HDMI_TX_D,
    input  logic             HDMI_TX_HS,
    input  logic             HDMI_TX_VS,
    input  logic             tm_stb,
    input  logic             tm_clk,
    input  logic             tm_data,
    output int               mismatches,
    output int               other_errors,
    output int               frames,
    output int               checked_frames
);

    localparam int h_total   = h_display + h_front + h_sync + h_back;
    localparam int v_total   = v_display + v_front + v_sync + v_back;
    localparam int line_clk  = h_total * pix_div;
    localparam int frame_clk = line_clk * v_total;

    // TM1638 commands from the datasheet
    localparam logic [7:0] exp_cmd_data    = 8'h40;  // Write with auto-increment
    localparam logic [7:0] exp_cmd_addr    = 8'hc0;  // Address 0
    localparam logic [7:0] exp_cmd_display = 8'h8f;  // Display on at full brightness

    int          k;            // Clock edges since reset
    int          last_change;  // Edge of last count change
    logic        tick_m;
    logic [15:0] count_m;
    logic [7:0]  led_m;
    logic [7:0]  led_prev;     // LED value before the last edge
    int          hs_fall_prev, vs_fall_prev;
    logic        hs_q, vs_q, stb_q, sclk_q;
    int          grp, nbits, stb_hi;
    logic [7:0]  sbyte;
    logic [7:0]  bytes [32];
    logic [7:0]  frame_led;
    logic [15:0] frame_count;
    logic        frame_stable;

    // Hex digits in hgfedcba order
    function automatic logic [7:0] hex_seg(input logic [3:0] n);
        logic [7:0] t [16] = '{8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66, 8'h6d, 8'h7d, 8'h07,
                               8'h7f, 8'h6f, 8'h77, 8'h7c, 8'h39, 8'h5e, 8'h79, 8'h71};
        return t[n];
    endfunction

    task automatic compare(input string name, input logic [31:0] exp, input logic [31:0] got);
        if (exp !== got)
        begin
            $display("MISMATCH t=%0t %s exp=%h got=%h", $time, name, exp, got);
            mismatches++;
        end
    endtask

    task automatic protocol_error(input string what);
        $display("Error at %0t: %s", $time, what);
        other_errors++;
    endtask

    //--------------------------------------------------
    // Count model updated on the DUT's clock edge

    always @(posedge clk)
    begin
        if (rst)
        begin
            k           = 0;
            tick_m      = 1'b0;
            count_m     = '0;
            led_m       = '0;
            led_prev    = '0;
            last_change = 0;
        end
        else
        begin
            led_prev = led_m;
            led_m    = count_m[7:0];  // LED trails count by a cycle
            if (tick_m && KEY[0])     // Button released
            begin
                count_m     = count_m + 16'(SW) + 16'd1;
                last_change = k + 1;
            end
            k++;
            tick_m = (k % tick_cycles == 0);
        end
    end

    //--------------------------------------------------
    // Output checks at the falling edge

    initial
    begin
        mismatches     = 0;
        other_errors   = 0;
        frames         = 0;
        checked_frames = 0;
    end

    always @(negedge clk)
    begin
        int          p, hx, vy;
        logic        de;
        logic [23:0] d;
        if (rst)
        begin
            hs_q         = 1'b1;
            vs_q         = 1'b1;
            stb_q        = 1'b1;
            sclk_q       = 1'b1;
            hs_fall_prev = -1;
            vs_fall_prev = -1;
            grp          = 0;
            nbits        = 0;
            stb_hi       = 0;
        end
        else
        begin
            compare("LED", led_m, LED);
            if (k >= 1)
            begin
                p  = (k - 1) / pix_div;          // Pixel index of the registered position
                hx = p % h_total;
                vy = (p / h_total) % v_total;
                de = (hx < h_display) && (vy < v_display);
                d  = de ? {4'(hx), 4'hf, 4'(vy), 4'hf, count_m[3:0], 4'hf}
                        : {4'h0, 4'hf, 4'h0, 4'hf, 4'h0, 4'hf};
                compare("HDMI_TX_DE", de, HDMI_TX_DE);
                compare("HDMI_TX_D", d, HDMI_TX_D);
                compare("HDMI_TX_CLK", ((k - 1) % pix_div) < pix_div / 2, HDMI_TX_CLK);
            end
            // Raster sync periods, widths and positions
            if (hs_q && !HDMI_TX_HS)
            begin
                compare("hs_start", h_display + h_front, hx);
                if (hs_fall_prev >= 0)
                    compare("hs_period", line_clk, k - hs_fall_prev);
                hs_fall_prev = k;
            end
            if (!hs_q && HDMI_TX_HS && hs_fall_prev >= 0)
                compare("hs_width", h_sync * pix_div, k - hs_fall_prev);
            if (vs_q && !HDMI_TX_VS)
            begin
                compare("vs_start", v_display + v_front, vy);
                if (vs_fall_prev >= 0)
                    compare("vs_period", frame_clk, k - vs_fall_prev);
                vs_fall_prev = k;
            end
            if (!vs_q && HDMI_TX_VS && vs_fall_prev >= 0)
                compare("vs_width", v_sync * line_clk, k - vs_fall_prev);
            hs_q = HDMI_TX_HS;
            vs_q = HDMI_TX_VS;

            // Serial groups
            if (stb_q && !tm_stb)
            begin
                if (stb_hi < 2 * sio_div)
                    protocol_error($sformatf("strobe high only %0d clocks", stb_hi));
                nbits = 0;
                if (grp == 0)  // Frame start snapshot
                begin
                    frame_led    = led_prev;
                    frame_count  = count_m;
                    frame_stable = (k - last_change) >= 2 * frame_clk;
                end
            end
            if (!tm_stb && tm_clk && !sclk_q)
            begin
                sbyte = {tm_data, sbyte[7:1]};  // LSB first
                nbits++;
                if (nbits % 8 == 0 && nbits / 8 <= 32)
                    bytes[nbits / 8 - 1] = sbyte;
            end
            if (!stb_q && tm_stb)
                end_group();
            stb_hi = tm_stb ? stb_hi + 1 : 0;
            stb_q  = tm_stb;
            sclk_q = tm_clk;
        end
    end

    task automatic end_group();
        int exp_bytes;
        exp_bytes = (grp == 1) ? 17 : 1;
        if (nbits != 8 * exp_bytes)
            protocol_error($sformatf("serial group %0d had %0d bits", grp, nbits));
        else if (grp == 0)
            compare("tm_cmd_data", exp_cmd_data, bytes[0]);
        else if (grp == 2)
            compare("tm_cmd_display", exp_cmd_display, bytes[0]);
        else
        begin
            compare("tm_cmd_addr", exp_cmd_addr, bytes[0]);
            for (int i = 0; i < w_tm_digit; i++)
            begin
                compare($sformatf("tm_led%0d", i), {7'b0, frame_led[i]}, bytes[2 + 2 * i]);
                if (frame_stable)
                    compare($sformatf("tm_digit%0d", i),
                            hex_seg(i < 4 ? frame_count[4 * i +: 4] : 4'h0), bytes[1 + 2 * i]);
            end
            if (frame_stable)
                checked_frames++;
        end
        if (grp == 2)
            frames++;
        grp = (grp + 1) % 3;
    endtask

endmodule

`default_nettype wire

// File: source/board_top.sv
`timescale 1ns/1ps
`default_nettype none

module board_top
    import board_pkg::*;
    import video_pkg::*;
#(
    parameter int clk_mhz     = 50,
    parameter int tick_cycles = clk_mhz * 250_000,  // Four ticks per second
    parameter int pix_div     = clk_mhz / 25,       // 25 MHz pixel rate
    parameter int sio_div     = clk_mhz,            // 500 kHz serial clock
    parameter int h_display   = vga_h_display,
    parameter int h_front     = vga_h_front,
    parameter int h_sync      = vga_h_sync,
    parameter int h_back      = vga_h_back,
    parameter int v_display   = vga_v_display,
    parameter int v_front     = vga_v_front,
    parameter int v_sync      = vga_v_sync,
    parameter int v_back      = vga_v_back
)
(
    input  logic             clk,
    input  logic             rst,
    input  logic [w_key-1:0] KEY,
    input  logic [w_sw-1:0]  SW,
    output logic [w_led-1:0] LED,
    output logic             HDMI_TX_CLK,
    output logic             HDMI_TX_DE,
    output logic [23:0]      HDMI_TX_D,
    output logic             HDMI_TX_HS,
    output logic             HDMI_TX_VS,
    output logic             tm_stb,
    output logic             tm_clk,
    output logic             tm_data
);

    localparam int w_x = $clog2(h_display);
    localparam int w_y = $clog2(v_display);

    logic                  tick;
    logic                  pixel_en;
    logic                  display_on;
    logic [w_x-1:0]        x;
    logic [w_y-1:0]        y;
    logic [w_key-1:0]      key;
    logic [w_seg-1:0]      abcdefgh;
    logic [w_seg-1:0]      hgfedcba;  // Segment a in bit 0 for the TM1638
    logic [w_tm_digit-1:0] digit;
    logic [w_red-1:0]      red;
    logic [w_green-1:0]    green;
    logic [w_blue-1:0]     blue;

    //------------------------------------------------
    // Pin glue

    assign key        = ~KEY;  // Buttons pull low
    assign HDMI_TX_DE = display_on;
    assign HDMI_TX_D  = {red,   {(8 - w_red)   {1'b1}},  // Pad each channel to 8 bits
                         green, {(8 - w_green) {1'b1}},
                         blue,  {(8 - w_blue)  {1'b1}}};

    for (genvar i = 0; i < w_seg; i++)
    begin : g_seg_rev
        assign hgfedcba[i] = abcdefgh[w_seg - 1 - i];
    end

    //------------------------------------------------
    // Blocks

    tick_gen #(.tick_cycles (tick_cycles)) i_tick_gen
    (
        .clk  (clk),
        .rst  (rst),
        .tick (tick)
    );

    vga_timing
    #(
        .pix_div   (pix_div),
        .h_display (h_display),
        .h_front   (h_front),
        .h_sync    (h_sync),
        .h_back    (h_back),
        .v_display (v_display),
        .v_front   (v_front),
        .v_sync    (v_sync),
        .v_back    (v_back),
        .w_x       (w_x),
        .w_y       (w_y)
    )
    i_vga_timing
    (
        .clk        (clk),
        .rst        (rst),
        .hs         (HDMI_TX_HS),
        .vs         (HDMI_TX_VS),
        .display_on (display_on),
        .pixel_en   (pixel_en),
        .pixel_clk  (HDMI_TX_CLK),
        .x          (x),
        .y          (y)
    );

    lab_top #(.h_display (h_display), .w_x (w_x), .w_y (w_y)) i_lab_top
    (
        .clk        (clk),
        .rst        (rst),
        .tick       (tick),
        .key        (key),
        .sw         (SW),
        .x          (x),
        .y          (y),
        .display_on (display_on),
        .pixel_en   (pixel_en),
        .led        (LED),
        .abcdefgh   (abcdefgh),
        .digit      (digit),
        .red        (red),
        .green      (green),
        .blue       (blue)
    );

    tm1638_controller #(.sio_div (sio_div)) i_tm1638_controller
    (
        .clk      (clk),
        .rst      (rst),
        .hgfedcba (hgfedcba),
        .digit    (digit),
        .led      (LED),  // Same LEDs on the module
        .sio_stb  (tm_stb),
        .sio_clk  (tm_clk),
        .sio_data (tm_data)
    );

endmodule

`default_nettype wire

// File: source/lab_top.sv
`timescale 1ns/1ps
`default_nettype none

module lab_top
    import board_pkg::*;
    import video_pkg::*;
#(
    parameter int h_display = vga_h_display,
    parameter int w_x       = $clog2(h_display),
    parameter int w_y       = $clog2(vga_v_display)
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tick,
    input  logic [w_key-1:0]      key,
    input  logic [w_sw-1:0]       sw,
    input  logic [w_x-1:0]        x,
    input  logic [w_y-1:0]        y,
    input  logic                  display_on,
    input  logic                  pixel_en,
    output logic [w_led-1:0]      led,
    output logic [w_seg-1:0]      abcdefgh,
    output logic [w_tm_digit-1:0] digit,
    output logic [w_red-1:0]      red,
    output logic [w_green-1:0]    green,
    output logic [w_blue-1:0]     blue
);

    localparam int w_scan = $clog2(w_tm_digit);

    logic [15:0]       count;
    logic [w_scan-1:0] scan;       // Digit being driven
    logic              line_wrap;  // Last visible pixel of a line
    logic [3:0]        nibble;

    //------------------------------------------------
    // Counter and LEDs

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            count <= '0;
            led   <= '0;
        end
        else
        begin
            if (tick && !key[0])
                count <= count + 16'(sw) + 16'd1;  // Key 0 holds
            led <= w_led'(count);
        end
    end

    //------------------------------------------------
    // Digit scan, one digit per displayed line

    assign line_wrap = pixel_en && display_on && (x == w_x'(h_display - 1));

    always_ff @(posedge clk)
    begin
        if (rst)
            scan <= '0;
        else if (line_wrap)
            scan <= scan + 1'b1;
    end

    assign digit  = w_tm_digit'(1) << scan;
    assign nibble = (scan < w_scan'(4)) ? count[4 * scan[1:0] +: 4] : 4'h0;  // High word zero

    always_comb
    begin
        case (nibble)
            4'h0    : abcdefgh = 8'b1111_1100;
            4'h1    : abcdefgh = 8'b0110_0000;
            4'h2    : abcdefgh = 8'b1101_1010;
            4'h3    : abcdefgh = 8'b1111_0010;
            4'h4    : abcdefgh = 8'b0110_0110;
            4'h5    : abcdefgh = 8'b1011_0110;
            4'h6    : abcdefgh = 8'b1011_1110;
            4'h7    : abcdefgh = 8'b1110_0000;
            4'h8    : abcdefgh = 8'b1111_1110;
            4'h9    : abcdefgh = 8'b1111_0110;
            4'ha    : abcdefgh = 8'b1110_1110;
            4'hb    : abcdefgh = 8'b0011_1110;
            4'hc    : abcdefgh = 8'b1001_1100;
            4'hd    : abcdefgh = 8'b0111_1010;
            4'he    : abcdefgh = 8'b1001_1110;
            default : abcdefgh = 8'b1000_1110;
        endcase
    end

    // Colour pattern, black outside the visible area
    assign red   = display_on ? w_red'(x)       : '0;
    assign green = display_on ? w_green'(y)     : '0;
    assign blue  = display_on ? w_blue'(count)  : '0;

endmodule

`default_nettype wire

// File: source/tm1638_controller.sv
`timescale 1ns/1ps
`default_nettype none

module tm1638_controller
    import board_pkg::*;
#(
    parameter int sio_div = 25
)
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic [w_seg-1:0]      hgfedcba,
    input  logic [w_tm_digit-1:0] digit,
    input  logic [w_led-1:0]      led,
    output logic                  sio_stb,
    output logic                  sio_clk,
    output logic                  sio_data
);

    localparam int w_div  = $clog2(sio_div + 1);
    localparam int w_byte = $clog2(2 * w_tm_digit);  // Segment and LED byte per digit

    typedef enum logic [2:0] {s_cmd, s_addr, s_data, s_disp, s_gap} state_t;

    state_t            state;
    state_t            next_st;  // Group that follows the gap
    logic [w_div-1:0]  div_cnt;
    logic              half;     // One strobe per sio_clk half period
    logic [3:0]        step;     // Bit index and clock phase within a byte
    logic [1:0]        gap_cnt;
    logic [w_byte-1:0] byte_cnt;
    logic [7:0]        cur_byte;

    logic [w_seg-1:0]  seg_live  [w_tm_digit];  // Follows the digit scan
    logic [w_seg-1:0]  seg_frame [w_tm_digit];  // Snapshot sent in one frame
    logic [w_led-1:0]  led_frame;

    //------------------------------------------------
    // Digit capture from the dynamic scan

    always_ff @(posedge clk)
    begin
        if (rst)
            seg_live <= '{default: '0};
        else
            for (int i = 0; i < w_tm_digit; i++)
                if (digit[i])
                    seg_live[i] <= hgfedcba;
    end

    //------------------------------------------------
    // Half period divider and byte source

    assign half = (div_cnt == w_div'(sio_div - 1));

    always_ff @(posedge clk)
    begin
        if (rst || half)
            div_cnt <= '0;
        else
            div_cnt <= div_cnt + 1'b1;
    end

    always_comb
    begin
        case (state)
            s_cmd   : cur_byte = tm_cmd_data;
            s_addr  : cur_byte = tm_cmd_addr;
            s_data  : cur_byte = byte_cnt[0] ? {7'b0, led_frame[byte_cnt[w_byte-1:1]]}
                                             : 8'(seg_frame[byte_cnt[w_byte-1:1]]);
            default : cur_byte = tm_cmd_display;
        endcase
    end

    //------------------------------------------------
    // Frame FSM

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state     <= s_gap;
            next_st   <= s_cmd;
            step      <= '0;
            gap_cnt   <= '0;
            byte_cnt  <= '0;
            sio_stb   <= 1'b1;
            sio_clk   <= 1'b1;
            sio_data  <= 1'b0;
            seg_frame <= '{default: '0};
            led_frame <= '0;
        end
        else
        begin
            if (!sio_clk)
                sio_data <= cur_byte[step[3:1]];  // Settles one clock after the fall, LSB first

            if (half)
            begin
                if (state == s_gap)
                begin
                    gap_cnt <= gap_cnt + 1'b1;  // Wraps to zero for the next gap
                    if (gap_cnt == 2'd0)
                        sio_stb <= 1'b1;  // Clock is already high here
                    if (gap_cnt == 2'd3)
                    begin
                        sio_stb <= 1'b0;
                        state   <= next_st;
                        if (next_st == s_cmd)
                        begin
                            seg_frame <= seg_live;  // Frame start snapshot
                            led_frame <= led;
                        end
                    end
                end
                else
                begin
                    step    <= step + 1'b1;
                    sio_clk <= step[0];  // Low on even steps, rising on odd
                    if (step == 4'd15)
                    begin
                        case (state)
                            s_cmd :
                            begin
                                state   <= s_gap;
                                next_st <= s_addr;
                            end
                            s_addr :
                            begin
                                state    <= s_data;  // Strobe stays low into the payload
                                byte_cnt <= '0;
                            end
                            s_data :
                            begin
                                byte_cnt <= byte_cnt + 1'b1;
                                if (byte_cnt == w_byte'(2 * w_tm_digit - 1))
                                begin
                                    state   <= s_gap;
                                    next_st <= s_disp;
                                end
                            end
                            default :
                            begin
                                state   <= s_gap;  // Display command closes the frame
                                next_st <= s_cmd;
                            end
                        endcase
                    end
                end
            end
        end
    end

    // Group ends only after the last rising clock edge
    a_stb_rise : assert property (@(posedge clk) disable iff (rst) $rose(sio_stb) |-> sio_clk);

endmodule

`default_nettype wire

// File: source/vga_timing.sv
`timescale 1ns/1ps
`default_nettype none

module vga_timing
    import video_pkg::*;
#(
    parameter int pix_div   = 2,
    parameter int h_display = vga_h_display,
    parameter int h_front   = vga_h_front,
    parameter int h_sync    = vga_h_sync,
    parameter int h_back    = vga_h_back,
    parameter int v_display = vga_v_display,
    parameter int v_front   = vga_v_front,
    parameter int v_sync    = vga_v_sync,
    parameter int v_back    = vga_v_back,
    parameter int w_x       = $clog2(h_display),
    parameter int w_y       = $clog2(v_display)
)
(
    input  logic           clk,
    input  logic           rst,
    output logic           hs,
    output logic           vs,
    output logic           display_on,
    output logic           pixel_en,
    output logic           pixel_clk,
    output logic [w_x-1:0] x,
    output logic [w_y-1:0] y
);

    localparam int h_total   = h_display + h_front + h_sync + h_back;
    localparam int v_total   = v_display + v_front + v_sync + v_back;
    localparam int h_sync_lo = h_display + h_front;  // First pixel of the hs pulse
    localparam int v_sync_lo = v_display + v_front;  // First line of the vs pulse
    localparam int w_h       = $clog2(h_total);
    localparam int w_v       = $clog2(v_total);
    localparam int w_pix     = $clog2(pix_div + 1);

    logic [w_pix-1:0] pix_cnt;  // Clocks within the current pixel
    logic [w_h-1:0]   h_cnt;    // Pixel within the line
    logic [w_v-1:0]   v_cnt;    // Line within the frame

    assign pixel_en = (pix_cnt == w_pix'(pix_div - 1));  // Last clock of a pixel

    //------------------------------------------------
    // Pixel divider and raster counters

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            pix_cnt <= '0;
            h_cnt   <= '0;
            v_cnt   <= '0;
        end
        else if (pixel_en)
        begin
            pix_cnt <= '0;
            if (h_cnt == w_h'(h_total - 1))
            begin
                h_cnt <= '0;  // Line wrap
                if (v_cnt == w_v'(v_total - 1))
                    v_cnt <= '0;  // Frame wrap
                else
                    v_cnt <= v_cnt + 1'b1;
            end
            else
            begin
                h_cnt <= h_cnt + 1'b1;
            end
        end
        else
        begin
            pix_cnt <= pix_cnt + 1'b1;
        end
    end

    //------------------------------------------------
    // Registered sync, enable and position

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            hs         <= 1'b1;
            vs         <= 1'b1;
            display_on <= 1'b0;
            pixel_clk  <= 1'b0;
        end
        else
        begin
            hs         <= !(h_cnt >= h_sync_lo && h_cnt < h_sync_lo + h_sync);
            vs         <= !(v_cnt >= v_sync_lo && v_cnt < v_sync_lo + v_sync);
            display_on <= (h_cnt < h_display) && (v_cnt < v_display);
            pixel_clk  <= (pix_cnt < w_pix'(pix_div / 2));  // High in first half of pixel
        end
    end

    always_ff @(posedge clk)
    begin
        x <= w_x'(h_cnt);  // Same stage as display_on
        y <= w_y'(v_cnt);
    end

    // Position stays inside the visible area
    a_x_visible : assert property (@(posedge clk) disable iff (rst)
        display_on |-> (x < h_display) && (y < v_display));

endmodule

`default_nettype wire

// File: source/tick_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tick_gen
#(
    parameter int tick_cycles = 50
)
(
    input  logic clk,
    input  logic rst,
    output logic tick
);

    localparam int w_cnt = $clog2(tick_cycles + 1);

    logic [w_cnt-1:0] cnt;  // Clocks left until the next tick

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            cnt  <= w_cnt'(tick_cycles - 1);
            tick <= 1'b0;
        end
        else if (cnt == '0)
        begin
            cnt  <= w_cnt'(tick_cycles - 1);  // Reload on expiry
            tick <= 1'b1;
        end
        else
        begin
            cnt  <= cnt - 1'b1;
            tick <= 1'b0;
        end
    end

    // Single-cycle strobe
    a_tick_single : assert property (@(posedge clk) disable iff (rst) tick |=> !tick);

endmodule

`default_nettype wire

// File: source/video_pkg.sv
`default_nettype none

package video_pkg;

    //------------------------------------------------
    // Colour channel widths

    localparam int w_red   = 4;
    localparam int w_green = 4;
    localparam int w_blue  = 4;

    //------------------------------------------------
    // 640x480 at 60 Hz, counted in pixels and lines

    localparam int vga_h_display = 640;  // Visible pixels
    localparam int vga_h_front   = 16;
    localparam int vga_h_sync    = 96;
    localparam int vga_h_back    = 48;

    localparam int vga_v_display = 480;  // Visible lines
    localparam int vga_v_front   = 10;
    localparam int vga_v_sync    = 2;
    localparam int vga_v_back    = 33;

endpackage

`default_nettype wire

// File: source/board_pkg.sv
`default_nettype none

package board_pkg;

    //------------------------------------------------
    // Board I/O widths

    localparam int w_key      = 2;  // Push buttons
    localparam int w_sw       = 3;  // Slide switches
    localparam int w_led      = 8;  // Board LEDs, mirrored on the TM1638
    localparam int w_tm_digit = 8;  // TM1638 digit positions
    localparam int w_seg      = 8;  // Seven segments plus dot

    //------------------------------------------------
    // TM1638 command bytes

    localparam logic [7:0] tm_cmd_data    = 8'h40;  // Write data, auto-increment address
    localparam logic [7:0] tm_cmd_addr    = 8'hc0;  // Start address 0
    localparam logic [7:0] tm_cmd_display = 8'h8f;  // Display on, brightest pulse width

endpackage

`default_nettype wire
